//--- tb.f
design/mipsPkg.sv
design/controller.sv
design/regFile.sv
design/alu.sv
design/loadStoreUnit.sv
design/mipsCore.sv
bench/wbMemory.sv
bench/tbTop.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f tb.f -Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log

if grep -q "test passed" sim.log; then
    exit 0
else
    exit 1
fi

//--- bench/tbTop.sv
`timescale 1ns/1ns

module tbTop;

    localparam int NumStores = 16;
    localparam int NumTests  = 6;
    localparam int EndFetch  = 36;
    localparam int LimitNs   = 40 * 5 * 4 * 20 + 8 * 20;

    logic        clk;
    logic        rstN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] datW;
    logic [31:0] datR;
    logic        ack;

    logic [31:0] expAdr [NumStores];
    logic [31:0] expDat [NumStores];
    logic [3:0]  expSel [NumStores];
    int          expTest [NumStores];
    int          testErrors [NumTests];
    int          storeIdx;
    int          fetchIdx;
    int          passCount;
    int          failCount;
    logic        fetchDone;
    logic        aluFetch;

    mipsCore DUT (
        .clk(clk), .rstN(rstN), .datR(datR), .ack(ack), .cyc(cyc), .stb(stb),
        .we(we), .sel(sel), .adr(adr), .datW(datW)
    );

    wbMemory uMemory (
        .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .sel(sel),
        .adr(adr), .datW(datW), .datR(datR), .ack(ack)
    );

    ////////////////////
    // Expected results

    task automatic addStore(input int idx, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] s, input int t);
        expAdr[idx]  = a;
        expDat[idx]  = d;
        expSel[idx]  = s;
        expTest[idx] = t;
    endtask

    // Fetch order from the next-PC rule, loop at 0x7C
    function automatic logic [31:0] expFetch(input int idx);
        if (idx < 28) begin
            return 32'(idx * 4);
        end
        case (idx)
            28:      return 32'h74;
            29:      return 32'hC0;
            30:      return 32'hC4;
            31:      return 32'h78;
            default: return 32'h7C;
        endcase
    endfunction

    function automatic int fetchTest(input int idx);
        return (idx < 29) ? 3 : 4;
    endfunction

    // Instructions that only use the ALU and write a register
    function automatic logic isAluInstr(input logic [31:0] word);
        logic [5:0] op;
        logic [5:0] fn;
        op = word[31:26];
        fn = word[5:0];
        if (op == mipsPkg::OpSpecial) begin
            return (fn == mipsPkg::FnAdd) || (fn == mipsPkg::FnSub);
        end
        return (op == mipsPkg::OpOri) || (op == mipsPkg::OpLui);
    endfunction

    initial begin
        addStore(0, 32'h200, 32'h12345678 + 32'hF0000001, 4'hF, 0);
        addStore(1, 32'h204, 32'h12345678 - 32'hF0000001, 4'hF, 0);
        addStore(2, 32'h208, 32'hF0000001 + 32'hF0000001, 4'hF, 0);
        addStore(3, 32'h210, 32'h56785678, 4'h3, 1);
        addStore(4, 32'h212, 32'h56785678, 4'hC, 1);
        addStore(5, 32'h214, 32'h78787878, 4'h1, 1);
        addStore(6, 32'h215, 32'h78787878, 4'h2, 1);
        addStore(7, 32'h216, 32'h78787878, 4'h4, 1);
        addStore(8, 32'h217, 32'h78787878, 4'h8, 1);
        addStore(9, 32'h220, 32'h9ABCF0E1, 4'hF, 2);
        addStore(10, 32'h224, 32'hFFFFF0E1, 4'hF, 2);
        addStore(11, 32'h228, 32'hFFFF9ABC, 4'hF, 2);
        addStore(12, 32'h22C, 32'hFFFFFFF0, 4'hF, 2);
        addStore(13, 32'h230, 32'hFFFFFF9A, 4'hF, 2);
        // Link value is the jal address plus 4
        addStore(14, 32'h238, 32'h74 + 32'h4, 4'hF, 4);
        addStore(15, 32'h23C, 32'h12345678, 4'hF, 4);
        for (int t = 0; t < NumTests; t++) begin
            testErrors[t] = 0;
        end
    end

    // Completed instruction fetch
    assign fetchDone = stb && ack && !we && (DUT.state == mipsPkg::StFetch);
    assign aluFetch  = fetchDone && isAluInstr(datR);

    // Completed transfers
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            storeIdx <= 0;
            fetchIdx <= 0;
        end else if (stb && ack) begin
            if (we) begin
                storeIdx <= storeIdx + 1;
            end else if (fetchDone) begin
                fetchIdx <= fetchIdx + 1;
            end
        end
    end

    ////////////////////
    // Checks

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && ack && we && storeIdx < NumStores) |-> (adr == expAdr[storeIdx]))
        else begin
            $display("[FAIL] adr: got %h, expected %h", $sampled(adr),
                     expAdr[$sampled(storeIdx)]);
            testErrors[expTest[$sampled(storeIdx)]]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && ack && we && storeIdx < NumStores) |-> (datW == expDat[storeIdx]))
        else begin
            $display("[FAIL] datW: got %h, expected %h", $sampled(datW),
                     expDat[$sampled(storeIdx)]);
            testErrors[expTest[$sampled(storeIdx)]]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && ack && we && storeIdx < NumStores) |-> (sel == expSel[storeIdx]))
        else begin
            $display("[FAIL] sel: got %h, expected %h", $sampled(sel),
                     expSel[$sampled(storeIdx)]);
            testErrors[expTest[$sampled(storeIdx)]]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && ack && we) |-> (storeIdx < NumStores && adr != 32'h234))
        else begin
            $display("Unexpected store to address %h", $sampled(adr));
            testErrors[3]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        fetchDone |-> (adr == expFetch(fetchIdx)))
        else begin
            $display("[FAIL] fetch adr: got %h, expected %h", $sampled(adr),
                     expFetch($sampled(fetchIdx)));
            testErrors[fetchTest($sampled(fetchIdx))]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        fetchDone |-> (sel == 4'hF))
        else begin
            $display("[FAIL] fetch sel: got %h, expected %h", $sampled(sel), 4'hF);
            testErrors[5]++;
        end

    // Bus protocol under wait states
    assert property (@(posedge clk) disable iff (!rstN)
        cyc == stb)
        else begin
            $display("[FAIL] cyc: got %h, expected %h", $sampled(cyc), $sampled(stb));
            testErrors[5]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we) && $stable(sel)
                           && $stable(datW)))
        else begin
            $display("Bus request dropped or changed before ack at adr %h", $sampled(adr));
            testErrors[5]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && ack) |=> !stb)
        else begin
            $display("Request stayed active after its ack at adr %h", $sampled(adr));
            testErrors[5]++;
        end

    assert property (@(posedge clk) disable iff (!rstN)
        ack |-> stb)
        else begin
            $display("Ack seen with no request on the bus");
            testErrors[5]++;
        end

    // One execute cycle, then the next fetch request
    assert property (@(posedge clk) disable iff (!rstN)
        $past(aluFetch, 2) |-> (stb && !we))
        else begin
            $display("ALU instruction did not go back to fetch after one execute cycle");
            testErrors[5]++;
        end

    ////////////////////
    // Clock, reset, run

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        #(LimitNs);
        $display("Timeout: program did not reach its final loop in %0d ns", LimitNs);
        $display("test failed");
        $finish;
    end

    initial begin
        string names [NumTests];
        names[0] = "arithmetic";
        names[1] = "sub-word stores";
        names[2] = "loads";
        names[3] = "beq";
        names[4] = "jal and jr";
        names[5] = "bus handshake";
        passCount = 0;
        failCount = 0;
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        assert (!cyc && !stb && !we)
            else begin
                $display("Bus request active while the core is in reset");
                testErrors[5]++;
            end
        rstN = 1'b1;
        wait (storeIdx == NumStores && fetchIdx >= EndFetch);
        @(posedge clk);
        for (int t = 0; t < NumTests; t++) begin
            if (testErrors[t] == 0) begin
                $display("%s: ok", names[t]);
                passCount++;
            end else begin
                $display("%s: %0d errors", names[t], testErrors[t]);
                failCount++;
            end
        end
        $display("%0d tests ok, %0d tests with errors", passCount, failCount);
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- bench/wbMemory.sv
`timescale 1ns/1ns

module wbMemory (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  sel,
    input  logic [31:0] adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack
);

    logic [31:0] mem [256];
    logic [31:0] rng;
    logic [1:0]  waitLeft;
    logic        busy;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    ////////////////////
    // Program assembly

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
        return {mipsPkg::OpSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] imm);
        return {op, imm};
    endfunction

    initial begin
        // Background pattern, unique per word address
        for (int idx = 0; idx < 256; idx++) begin
            mem[idx] = 32'hA500_0000 | 32'(idx * 4);
        end
        mem[0]  = encI(mipsPkg::OpLui, 5'd0, 5'd1, 16'h1234);
        mem[1]  = encI(mipsPkg::OpOri, 5'd1, 5'd1, 16'h5678);
        mem[2]  = encI(mipsPkg::OpLui, 5'd0, 5'd2, 16'hF000);
        mem[3]  = encI(mipsPkg::OpOri, 5'd2, 5'd2, 16'h0001);
        mem[4]  = encR(5'd1, 5'd2, 5'd3, mipsPkg::FnAdd);
        mem[5]  = encR(5'd1, 5'd2, 5'd4, mipsPkg::FnSub);
        mem[6]  = encI(mipsPkg::OpSw, 5'd0, 5'd3, 16'h0200);
        mem[7]  = encI(mipsPkg::OpSw, 5'd0, 5'd4, 16'h0204);
        mem[8]  = encR(5'd2, 5'd2, 5'd6, mipsPkg::FnAdd);
        mem[9]  = encI(mipsPkg::OpSw, 5'd0, 5'd6, 16'h0208);
        // Sub-word stores at every legal offset
        mem[10] = encI(mipsPkg::OpSh, 5'd0, 5'd1, 16'h0210);
        mem[11] = encI(mipsPkg::OpSh, 5'd0, 5'd1, 16'h0212);
        mem[12] = encI(mipsPkg::OpSb, 5'd0, 5'd1, 16'h0214);
        mem[13] = encI(mipsPkg::OpSb, 5'd0, 5'd1, 16'h0215);
        mem[14] = encI(mipsPkg::OpSb, 5'd0, 5'd1, 16'h0216);
        mem[15] = encI(mipsPkg::OpSb, 5'd0, 5'd1, 16'h0217);
        // Loads of the data word, stored back
        mem[16] = encI(mipsPkg::OpLw, 5'd0, 5'd7, 16'h0300);
        mem[17] = encI(mipsPkg::OpSw, 5'd0, 5'd7, 16'h0220);
        mem[18] = encI(mipsPkg::OpLh, 5'd0, 5'd8, 16'h0300);
        mem[19] = encI(mipsPkg::OpSw, 5'd0, 5'd8, 16'h0224);
        mem[20] = encI(mipsPkg::OpLh, 5'd0, 5'd9, 16'h0302);
        mem[21] = encI(mipsPkg::OpSw, 5'd0, 5'd9, 16'h0228);
        mem[22] = encI(mipsPkg::OpLb, 5'd0, 5'd10, 16'h0301);
        mem[23] = encI(mipsPkg::OpSw, 5'd0, 5'd10, 16'h022C);
        mem[24] = encI(mipsPkg::OpLb, 5'd0, 5'd11, 16'h0303);
        mem[25] = encI(mipsPkg::OpSw, 5'd0, 5'd11, 16'h0230);
        // Not taken, then taken over the store at 0x70
        mem[26] = encI(mipsPkg::OpBeq, 5'd1, 5'd2, 16'h0001);
        mem[27] = encI(mipsPkg::OpBeq, 5'd1, 5'd1, 16'h0001);
        mem[28] = encI(mipsPkg::OpSw, 5'd0, 5'd1, 16'h0234);
        mem[29] = encJ(mipsPkg::OpJal, 26'h30);
        mem[30] = encI(mipsPkg::OpSw, 5'd0, 5'd1, 16'h023C);
        mem[31] = encI(mipsPkg::OpBeq, 5'd0, 5'd0, 16'hFFFF);
        // Subroutine at 0xC0
        mem[48] = encI(mipsPkg::OpSw, 5'd0, 5'd31, 16'h0238);
        mem[49] = encR(5'd31, 5'd0, 5'd0, mipsPkg::FnJr);
        // Data word with top bits set in every half and odd byte
        mem[192] = 32'h9ABC_F0E1;
    end

    ////////////////////
    // Slave with random wait states

    initial begin
        rng      = 32'h53294071;
        datR     = 32'd0;
        ack      = 1'b0;
        busy     = 1'b0;
        waitLeft = 2'd0;
    end

    always @(posedge clk) begin
        #2;
        if (!rstN) begin
            ack  = 1'b0;
            busy = 1'b0;
        end else if (ack) begin
            ack = 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                busy     = 1'b1;
                rng      = xorshift(rng);
                waitLeft = rng[1:0];
            end
            if (waitLeft == 2'd0) begin
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel[b]) begin
                            mem[adr[9:2]][8*b +: 8] = datW[8*b +: 8];
                        end
                    end
                end
                datR = mem[adr[9:2]];
                ack  = 1'b1;
                busy = 1'b0;
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
    end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ns

module mipsCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] datR,
    input  logic        ack,
    output logic        cyc,
    output logic        stb,
    output logic        we,
    output logic [3:0]  sel,
    output logic [31:0] adr,
    output logic [31:0] datW
);

    mipsPkg::stateT state;
    mipsPkg::instrT ir;
    logic [31:0]    pc;
    logic [31:0]    memAdr;
    logic [31:0]    loadReg;
    logic           ackQ;
    logic           busReq;

    // Decoded controls
    logic [4:0]     rs;
    logic [4:0]     rt;
    logic [15:0]    imm16;
    logic [25:0]    imm26;
    logic           branch;
    logic           jImm;
    logic           jReg;
    logic           extSigned;
    logic           regWrite;
    mipsPkg::wdSelT wdSel;
    logic [4:0]     a3;
    logic           aluBSrc;
    mipsPkg::aluOpT aluOp;
    logic           memWrite;
    mipsPkg::widthT width;
    logic           loadSign;
    logic           load;
    logic           store;

    // Datapath
    logic [31:0]    rd1;
    logic [31:0]    rd2;
    logic           rfWe;
    logic [31:0]    rfWd;
    logic [31:0]    extImm;
    logic [31:0]    aluB;
    logic [31:0]    aluY;
    logic           aluEqual;
    logic [31:0]    pcPlus4;
    logic [31:0]    branchTarget;
    logic [31:0]    jumpTarget;
    logic [31:0]    nextPc;
    logic [1:0]     lsAddrLow;
    logic [3:0]     lsSel;
    logic [31:0]    lsBusOut;
    logic [31:0]    lsLoadData;

    controller uController (
        .instr(ir), .rs(rs), .rt(rt), .imm16(imm16), .imm26(imm26),
        .branch(branch), .jImm(jImm), .jReg(jReg), .extSigned(extSigned),
        .regWrite(regWrite), .wdSel(wdSel), .a3(a3), .aluBSrc(aluBSrc),
        .aluOp(aluOp), .memWrite(memWrite), .width(width),
        .loadSign(loadSign), .load(load), .store(store)
    );

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .ra1(rs), .ra2(rt), .wa(a3),
        .we(rfWe), .wd(rfWd), .rd1(rd1), .rd2(rd2)
    );

    alu uAlu (
        .a(rd1), .b(aluB), .op(aluOp), .y(aluY), .equal(aluEqual)
    );

    loadStoreUnit uLsu (
        .addrLow(lsAddrLow), .width(width), .loadSign(loadSign),
        .storeData(rd2), .busData(datR), .sel(lsSel),
        .busOut(lsBusOut), .loadData(lsLoadData)
    );

    ////////////////////
    // Execute

    assign extImm = extSigned ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
    assign aluB   = aluBSrc ? extImm : rd2;

    // beq offset is always signed
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], imm26, 2'b00};

    always_comb begin
        nextPc = pcPlus4;
        if (jReg) begin
            nextPc = rd1;
        end else if (jImm) begin
            nextPc = jumpTarget;
        end else if (branch && aluEqual) begin
            nextPc = branchTarget;
        end
    end

    always_comb begin
        case (wdSel)
            mipsPkg::WdPcPlus4: rfWd = pcPlus4;
            mipsPkg::WdAlu:     rfWd = aluY;
            mipsPkg::WdMem:     rfWd = loadReg;
            default:            rfWd = 32'd0;
        endcase
    end

    // Loads write back later, in StWb
    assign rfWe = regWrite && (((state == mipsPkg::StExec) && (wdSel != mipsPkg::WdMem))
                               || (state == mipsPkg::StWb));

    // Live address while executing, latched afterwards
    assign lsAddrLow = (state == mipsPkg::StExec) ? aluY[1:0] : memAdr[1:0];

    ////////////////////
    // Sequencing

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= mipsPkg::StFetch;
            pc    <= 32'd0;
            ir    <= '0;
            ackQ  <= 1'b1;
        end else begin
            ackQ <= stb && ack;
            case (state)
                mipsPkg::StFetch: begin
                    if (stb && ack) begin
                        ir    <= datR;
                        state <= mipsPkg::StExec;
                    end
                end
                mipsPkg::StExec: begin
                    pc    <= nextPc;
                    state <= (load || store) ? mipsPkg::StMem : mipsPkg::StFetch;
                end
                mipsPkg::StMem: begin
                    if (stb && ack) begin
                        state <= load ? mipsPkg::StWb : mipsPkg::StFetch;
                    end
                end
                default: begin
                    state <= mipsPkg::StFetch;
                end
            endcase
        end
    end

    // Access address and load result
    always_ff @(posedge clk) begin
        if (state == mipsPkg::StExec) begin
            memAdr <= aluY;
        end
        if ((state == mipsPkg::StMem) && stb && ack) begin
            loadReg <= lsLoadData;
        end
    end

    ////////////////////
    // Wishbone master

    // Idle in reset and for one cycle after every ack
    assign busReq = (state == mipsPkg::StFetch) || (state == mipsPkg::StMem);
    assign stb    = busReq && !ackQ;
    assign cyc    = stb;
    assign we     = (state == mipsPkg::StMem) && memWrite;
    assign adr    = (state == mipsPkg::StMem) ? memAdr : pc;
    assign sel    = (state == mipsPkg::StMem) ? lsSel : 4'hF;
    assign datW   = lsBusOut;

    assert property (@(posedge clk) disable iff (!rstN)
        (stb && !ack) |=> ($stable(adr) && $stable(we)))
        else $error("mipsCore: request changed before ack, adr %h we %b", adr, we);

endmodule

//--- design/loadStoreUnit.sv
`timescale 1ns/1ns

module loadStoreUnit (
    input  logic [1:0]     addrLow,
    input  mipsPkg::widthT width,
    input  logic           loadSign,
    input  logic [31:0]    storeData,
    input  logic [31:0]    busData,
    output logic [3:0]     sel,
    output logic [31:0]    busOut,
    output logic [31:0]    loadData
);

    logic [15:0] halfIn;
    logic [7:0]  byteIn;

    ////////////////////
    // Store side

    // Value copied into every lane, sel picks the live ones
    always_comb begin
        case (width)
            mipsPkg::WidthHalf: begin
                busOut = {2{storeData[15:0]}};
                sel    = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            mipsPkg::WidthByte: begin
                busOut = {4{storeData[7:0]}};
                sel    = 4'b0001 << addrLow;
            end
            default: begin
                busOut = storeData;
                sel    = 4'b1111;
            end
        endcase
    end

    ////////////////////
    // Load side

    assign halfIn = addrLow[1] ? busData[31:16] : busData[15:0];

    always_comb begin
        case (addrLow)
            2'd1:    byteIn = busData[15:8];
            2'd2:    byteIn = busData[23:16];
            2'd3:    byteIn = busData[31:24];
            default: byteIn = busData[7:0];
        endcase
    end

    // Sign or zero fill for sub-word loads
    always_comb begin
        case (width)
            mipsPkg::WidthHalf: begin
                loadData = {{16{loadSign & halfIn[15]}}, halfIn};
            end
            mipsPkg::WidthByte: begin
                loadData = {{24{loadSign & byteIn[7]}}, byteIn};
            end
            default: begin
                loadData = busData;
            end
        endcase
    end

    // Halfword accesses must sit on an even address
    always_comb begin
        if (width == mipsPkg::WidthHalf) begin
            assert (addrLow[0] == 1'b0)
                else $error("loadStoreUnit: half access at offset %0d", addrLow);
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  mipsPkg::aluOpT op,
    output logic [31:0]    y,
    output logic           equal
);

    ////////////////////
    // Result

    always_comb begin
        case (op)
            mipsPkg::AluAdd: begin
                y = a + b;
            end
            mipsPkg::AluSub: begin
                y = a - b;
            end
            mipsPkg::AluOr: begin
                y = a | b;
            end
            mipsPkg::AluLui: begin
                // immediate lands in the upper half
                y = {b[15:0], 16'h0000};
            end
            default: begin
                y = a + b;
            end
        endcase
    end

    ////////////////////
    // Compare for beq

    // Operands are rs and rt when branching
    assign equal = (a == b);

endmodule

//--- design/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    // Register 0 never takes a write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= 32'd0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // Combinational reads
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    ////////////////////
    // Checks

    assert property (@(posedge clk) disable iff (!rstN)
        (ra1 == 5'd0) |-> (rd1 == 32'd0))
        else $error("regFile: rd1 = %h while reading r0", rd1);

endmodule

//--- design/controller.sv
`timescale 1ns/1ns

module controller (
    input  mipsPkg::instrT instr,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [15:0]    imm16,
    output logic [25:0]    imm26,
    output logic           branch,
    output logic           jImm,
    output logic           jReg,
    output logic           extSigned,
    output logic           regWrite,
    output mipsPkg::wdSelT wdSel,
    output logic [4:0]     a3,
    output logic           aluBSrc,
    output mipsPkg::aluOpT aluOp,
    output logic           memWrite,
    output mipsPkg::widthT width,
    output logic           loadSign,
    output logic           load,
    output logic           store
);

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] rd;

    logic isAdd;
    logic isSub;
    logic isOri;
    logic isLui;
    logic isLw;
    logic isLh;
    logic isLb;
    logic isSw;
    logic isSh;
    logic isSb;
    logic isBeq;
    logic isJal;
    logic isJr;

    logic calr;
    logic cali;

    // Field extraction
    assign op    = instr.r.op;
    assign funct = instr.r.funct;
    assign rd    = instr.r.rd;
    assign rs    = instr.r.rs;
    assign rt    = instr.i.rt;
    assign imm16 = instr.i.imm16;
    assign imm26 = instr.j.imm26;

    ////////////////////
    // Instruction recognition

    assign isAdd = (op == mipsPkg::OpSpecial) && (funct == mipsPkg::FnAdd);
    assign isSub = (op == mipsPkg::OpSpecial) && (funct == mipsPkg::FnSub);
    assign isJr  = (op == mipsPkg::OpSpecial) && (funct == mipsPkg::FnJr);
    assign isOri = (op == mipsPkg::OpOri);
    assign isLui = (op == mipsPkg::OpLui);
    assign isLw  = (op == mipsPkg::OpLw);
    assign isLh  = (op == mipsPkg::OpLh);
    assign isLb  = (op == mipsPkg::OpLb);
    assign isSw  = (op == mipsPkg::OpSw);
    assign isSh  = (op == mipsPkg::OpSh);
    assign isSb  = (op == mipsPkg::OpSb);
    assign isBeq = (op == mipsPkg::OpBeq);
    assign isJal = (op == mipsPkg::OpJal);

    // Class flags
    assign load   = isLw || isLh || isLb;
    assign store  = isSw || isSh || isSb;
    assign calr   = isAdd || isSub;
    assign cali   = isOri || isLui;
    assign branch = isBeq;
    assign jImm   = isJal;
    assign jReg   = isJr;

    ////////////////////
    // Datapath selects

    // ori wants zero extension, address offsets want sign
    assign extSigned = load || store;
    assign regWrite  = load || calr || cali || isJal;
    assign aluBSrc   = cali || load || store;
    assign memWrite  = store;
    assign loadSign  = isLh || isLb;

    assign a3 = calr           ? rd :
                (cali || load) ? rt :
                isJal          ? mipsPkg::RaReg :
                                 5'd0;

    assign wdSel = isJal          ? mipsPkg::WdPcPlus4 :
                   (calr || cali) ? mipsPkg::WdAlu :
                   load           ? mipsPkg::WdMem :
                                    mipsPkg::WdNone;

    assign aluOp = isSub ? mipsPkg::AluSub :
                   isOri ? mipsPkg::AluOr :
                   isLui ? mipsPkg::AluLui :
                           mipsPkg::AluAdd;

    assign width = (isLw || isSw) ? mipsPkg::WidthWord :
                   (isLh || isSh) ? mipsPkg::WidthHalf :
                   (isLb || isSb) ? mipsPkg::WidthByte :
                                    mipsPkg::WidthWord;

    // Core sequencing relies on a single class per word
    always_comb begin
        assert ($onehot0({load, store, branch, jImm, jReg}))
            else $error("controller: several class flags for instr %h", instr);
    end

endmodule

//--- design/mipsPkg.sv
package mipsPkg;

    ////////////////////
    // Opcodes and funct codes

    localparam logic [5:0] OpSpecial = 6'b000000;
    localparam logic [5:0] OpLui     = 6'b001111;
    localparam logic [5:0] OpOri     = 6'b001101;
    localparam logic [5:0] OpLw      = 6'b100011;
    localparam logic [5:0] OpLh      = 6'b100001;
    localparam logic [5:0] OpLb      = 6'b100000;
    localparam logic [5:0] OpSw      = 6'b101011;
    localparam logic [5:0] OpSh      = 6'b101001;
    localparam logic [5:0] OpSb      = 6'b101000;
    localparam logic [5:0] OpBeq     = 6'b000100;
    localparam logic [5:0] OpJal     = 6'b000011;

    // Only meaningful under OpSpecial
    localparam logic [5:0] FnAdd = 6'b100000;
    localparam logic [5:0] FnSub = 6'b100010;
    localparam logic [5:0] FnJr  = 6'b001000;

    // Link register for jal
    localparam logic [4:0] RaReg = 5'd31;

    ////////////////////
    // Instruction formats

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] imm26;
    } jTypeT;

    // Same 32 bits, three views
    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrT;

    ////////////////////
    // Select encodings

    typedef enum logic [4:0] {
        AluAdd = 5'd0,
        AluSub = 5'd1,
        AluOr  = 5'd3,
        AluLui = 5'd4
    } aluOpT;

    typedef enum logic [1:0] {
        WdPcPlus4 = 2'd0,
        WdAlu     = 2'd1,
        WdMem     = 2'd2,
        WdNone    = 2'd3
    } wdSelT;

    typedef enum logic [1:0] {
        WidthWord = 2'd0,
        WidthHalf = 2'd1,
        WidthByte = 2'd2
    } widthT;

    // Core FSM
    typedef enum logic [1:0] {
        StFetch = 2'd0,
        StExec  = 2'd1,
        StMem   = 2'd2,
        StWb    = 2'd3
    } stateT;

endpackage
